//--- memory/bootRom.hex
03 0A 11 18 1F 26 2D 34 3B 42 49 50 57 5E 65 6C 73 7A 81 88 8F 96 9D A4 AB B2 B9 C0 C7 CE D5 DC
E3 EA F1 F8 FF 06 0D 14 1B 22 29 30 37 3E 45 4C 53 5A 61 68 6F 76 7D 84 8B 92 99 A0 A7 AE B5 BC
C3 CA D1 D8 DF E6 ED F4 FB 02 09 10 17 1E 25 2C 33 3A 41 48 4F 56 5D 64 6B 72 79 80 87 8E 95 9C
A3 AA B1 B8 BF C6 CD D4 DB E2 E9 F0 F7 FE 05 0C 13 1A 21 28 2F 36 3D 44 4B 52 59 60 67 6E 75 7C
83 8A 91 98 9F A6 AD B4 BB C2 C9 D0 D7 DE E5 EC F3 FA 01 08 0F 16 1D 24 2B 32 39 40 47 4E 55 5C
63 6A 71 78 7F 86 8D 94 9B A2 A9 B0 B7 BE C5 CC D3 DA E1 E8 EF F6 FD 04 0B 12 19 20 27 2E 35 3C
43 4A 51 58 5F 66 6D 74 7B 82 89 90 97 9E A5 AC B3 BA C1 C8 CF D6 DD E4 EB F2 F9 00 07 0E 15 1C
23 2A 31 38 3F 46 4D 54 5B 62 69 70 77 7E 85 8C 93 9A A1 A8 AF B6 BD C4 CB D2 D9 E0 E7 EE F5 FC
03 0A 11 18 1F 26 2D 34 3B 42 49 50 57 5E 65 6C 73 7A 81 88 8F 96 9D A4 AB B2 B9 C0 C7 CE D5 DC
E3 EA F1 F8 FF 06 0D 14 1B 22 29 30 37 3E 45 4C 53 5A 61 68 6F 76 7D 84 8B 92 99 A0 A7 AE B5 BC
C3 CA D1 D8 DF E6 ED F4 FB 02 09 10 17 1E 25 2C 33 3A 41 48 4F 56 5D 64 6B 72 79 80 87 8E 95 9C
A3 AA B1 B8 BF C6 CD D4 DB E2 E9 F0 F7 FE 05 0C 13 1A 21 28 2F 36 3D 44 4B 52 59 60 67 6E 75 7C
83 8A 91 98 9F A6 AD B4 BB C2 C9 D0 D7 DE E5 EC F3 FA 01 08 0F 16 1D 24 2B 32 39 40 47 4E 55 5C
63 6A 71 78 7F 86 8D 94 9B A2 A9 B0 B7 BE C5 CC D3 DA E1 E8 EF F6 FD 04 0B 12 19 20 27 2E 35 3C
43 4A 51 58 5F 66 6D 74 7B 82 89 90 97 9E A5 AC B3 BA C1 C8 CF D6 DD E4 EB F2 F9 00 07 0E 15 1C
23 2A 31 38 3F 46 4D 54 5B 62 69 70 77 7E 85 8C 93 9A A1 A8 AF B6 BD C4 CB D2 D9 E0 E7 EE F5 FC

//--- compile.f
common/sbcPkg.sv
memory/memMap.sv
rtl/ioPorts.sv
rtl/busCycle.sv
rtl/s100Glue.sv
bench/tbS100Glue.sv

//--- Makefile
LOG := sim.log

sim:
	verilator --binary --timing --top-module tbS100Glue -f compile.f -o simv
	./obj_dir/simv 2>&1 | tee $(LOG)
	grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: sim clean

//--- bench/tbS100Glue.sv
// plays the CPU one bus cycle at a time; RAM chip model is 128K bytes and writes on the clock edge
`timescale 1ns/10ps
`default_nettype none

module tbS100Glue;

    localparam int CLK_HALF     = 4;                      // 8 ns period
    localparam int RESET_CYCLES = 16;
    localparam int DONE_LIMIT   = 12;                     // cycles before a cycle is given up
    localparam int BUS_OPS      = 60;                     // upper bound on bus cycles issued
    localparam int WATCHDOG_NS  = (RESET_CYCLES + BUS_OPS * (DONE_LIMIT + 4)) * 2 * CLK_HALF;

    logic           pll0_2MHz;
    logic           n_reset;
    logic           busReq;
    sbcPkg::busKind busKind;
    logic [15:0]    busAddr;
    logic [7:0]     busWData;
    logic           cycleDone;
    logic [7:0]     readData;
    logic [15:0]    ramAddr;
    logic           ramA16;
    logic           ramNCs;
    logic           ramNOe;
    logic           ramNWr;
    logic [7:0]     biDataOut;
    logic           biDataOe;
    logic [7:0]     biDataIn;
    logic [7:0]     ioByteSw;
    logic [7:0]     sbcLeds;
    logic [7:0]     frontPanel;
    logic [7:0]     s100DataIn;
    logic [15:0]    s100Addr;
    logic           sMemr;
    logic           sInp;
    logic           sOut;
    logic           nSWo;
    logic           pSync;
    logic           pDbin;
    logic           nPWr;
    logic [7:0]     s100DataOut;

    // what the last bus cycle looked like
    int             cycleLatency;
    logic [7:0]     cycleData;
    int             pSyncCount;
    logic           pSyncAtStart;
    logic           sawOe;
    logic           sawPwrLow;
    logic           sawDbin;
    logic           sawRamCs;
    logic           a16Seen;
    int             checkCount;
    int             errorCount;
    logic [31:0]    lcgState;
    logic [7:0]     ramMem [0:131071];                    // 128K x 8 static RAM

    s100Glue dut_i (.*);

    //////////////////////////////////////////////////////////////////////
    // clock and RAM chip model
    //////////////////////////////////////////////////////////////////////
    initial begin
        pll0_2MHz = 1'b0;
        forever #(CLK_HALF) pll0_2MHz = ~pll0_2MHz;
    end

    assign biDataIn = (!ramNCs && !ramNOe) ? ramMem[{ramA16, ramAddr}] : 8'hFF;  // idle bus high

    always @(posedge pll0_2MHz) begin
        if (!ramNCs && !ramNWr) begin
            ramMem[{ramA16, ramAddr}] <= biDataOut;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;   // 32-bit LCG step
        return lcgState;
    endfunction

    // boot ROM byte is addr * 7 + 3
    function automatic logic [7:0] romByte(input logic bank, input logic [7:0] lo);
        logic [15:0] a;
        a = {7'd0, bank, lo};
        a = a * 16'd7 + 16'd3;
        return a[7:0];
    endfunction

    task automatic expectValue(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checkCount++;
        if (got !== want) begin
            errorCount++;
            $display("ERROR %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, want);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // one CPU bus cycle sampled on every falling edge until cycleDone
    //////////////////////////////////////////////////////////////////////
    task automatic runCycle(input sbcPkg::busKind kind, input logic [15:0] addr,
                            input logic [7:0] wdata);
        int n;
        pSyncCount   = 0;
        pSyncAtStart = 1'b0;
        sawOe        = 1'b0;
        sawPwrLow    = 1'b0;
        sawDbin      = 1'b0;
        sawRamCs     = 1'b0;
        a16Seen      = 1'b0;
        @(negedge pll0_2MHz);
        busReq   = 1'b1;
        busKind  = kind;
        busAddr  = addr;
        busWData = wdata;
        n = 0;
        do begin
            @(negedge pll0_2MHz);
            busReq = 1'b0;                                // one-cycle strobe
            n++;
            if (pSync) begin
                pSyncCount++;
                pSyncAtStart = pSyncAtStart | (n == 1);
            end
            sawOe     |= biDataOe;
            sawPwrLow |= !nPWr;
            sawDbin   |= pDbin;
            if (!ramNCs) begin
                sawRamCs = 1'b1;
                a16Seen  = ramA16;                        // page bit while chip selected
            end
        end while (!cycleDone && n < DONE_LIMIT);
        if (!cycleDone) begin
            errorCount++;
            $display("cycleDone never came within %0d cycles, at %0d ns", DONE_LIMIT, $time);
        end
        cycleLatency = n;
        cycleData    = readData;
    endtask

    task automatic readExpect(input sbcPkg::busKind kind, input logic [15:0] addr,
                              input logic [7:0] want, input int wantLatency);
        runCycle(kind, addr, 8'h00);
        expectValue("readData", 32'(cycleData), 32'(want));
        expectValue("cycleDone latency", cycleLatency, wantLatency);
        expectValue("pDbin high during read", 32'(sawDbin), 1);
        expectValue("pDbin at cycleDone", 32'(pDbin), 0);
        expectValue("nPWr low during read", 32'(sawPwrLow), 0);
    endtask

    task automatic writeExpect(input sbcPkg::busKind kind, input logic [15:0] addr,
                               input logic [7:0] data, input int wantLatency);
        runCycle(kind, addr, data);
        expectValue("cycleDone latency", cycleLatency, wantLatency);
        expectValue("pDbin high during write", 32'(sawDbin), 0);
    endtask

    //////////////////////////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////////////////////////
    task automatic romAfterReset();
        logic [31:0] r;
        expectValue("sbcLeds", 32'(sbcLeds), 32'hFF);     // LEDs dark
        expectValue("cycleDone", 32'(cycleDone), 0);
        expectValue("pSync", 32'(pSync), 0);
        expectValue("pDbin", 32'(pDbin), 0);
        expectValue("nPWr", 32'(nPWr), 1);
        expectValue("ramNCs", 32'(ramNCs), 1);
        expectValue("ramNOe", 32'(ramNOe), 1);
        expectValue("ramNWr", 32'(ramNWr), 1);
        expectValue("biDataOe", 32'(biDataOe), 0);
        repeat (4) begin
            r = nextRand();
            readExpect(sbcPkg::MEM_READ, {sbcPkg::ROM_PAGE, r[7:0]}, romByte(1'b0, r[7:0]), 4);
            expectValue("sMemr", 32'(sMemr), 1);
            expectValue("pSync high cycles", pSyncCount, 1);
            expectValue("pSync in first cycle", 32'(pSyncAtStart), 1);
            expectValue("ramNCs low in ROM cycle", 32'(sawRamCs), 0);
        end
    endtask

    task automatic ramWriteRead();
        logic [31:0] r;
        logic [15:0] addr;
        logic [15:0] addrs [6];
        logic [7:0]  datas [6];
        for (int i = 0; i < 6; i++) begin
            r    = nextRand();
            addr = r[15:0];
            addr[14:12] = 3'(i);                          // keeps the six addresses apart
            if (addr[15:8] == 8'h00) begin
                addr[8] = 1'b1;                           // stay above the ROM window
            end
            addrs[i] = addr;
            datas[i] = r[23:16];
            writeExpect(sbcPkg::MEM_WRITE, addr, r[23:16], 2);
            expectValue("biDataOe during write", 32'(sawOe), 1);
            expectValue("nPWr low during write", 32'(sawPwrLow), 1);
        end
        for (int i = 0; i < 6; i++) begin
            readExpect(sbcPkg::MEM_READ, addrs[i], datas[i], 2);
        end
        writeExpect(sbcPkg::IO_WRITE, 16'h0036, 8'h01, 3);        // page 1
        writeExpect(sbcPkg::MEM_WRITE, 16'h1234, 8'h5A, 2);
        expectValue("ramA16", 32'(a16Seen), 1);
        writeExpect(sbcPkg::MEM_WRITE, 16'h9234, 8'hC3, 2);
        expectValue("ramA16", 32'(a16Seen), 0);                  // upper 32K never paged
        writeExpect(sbcPkg::IO_WRITE, 16'h0036, 8'h00, 3);
        writeExpect(sbcPkg::MEM_WRITE, 16'h1234, 8'h3C, 2);
        expectValue("ramA16", 32'(a16Seen), 0);
        readExpect(sbcPkg::MEM_READ, 16'h1234, 8'h3C, 2);
        readExpect(sbcPkg::MEM_READ, 16'h9234, 8'hC3, 2);
        writeExpect(sbcPkg::IO_WRITE, 16'h0036, 8'h01, 3);
        readExpect(sbcPkg::MEM_READ, 16'h1234, 8'h5A, 2);        // page 1 copy kept
        writeExpect(sbcPkg::IO_WRITE, 16'h0036, 8'h00, 3);
    endtask

    task automatic ioPortAccess();
        logic [31:0] r;
        r = nextRand();
        ioByteSw   = ~r[7:0];                                    // other read sources differ
        s100DataIn = ~r[7:0];
        writeExpect(sbcPkg::IO_WRITE, {r[15:8], sbcPkg::PORT_LEDBAR}, r[7:0], 3);
        expectValue("s100Addr high byte", 32'(s100Addr[15:8]), 0);
        expectValue("sbcLeds", 32'(sbcLeds), {24'h000000, ~r[7:0]});
        readExpect(sbcPkg::IO_READ, {r[23:16], sbcPkg::PORT_LEDBAR}, r[7:0], 3);
        writeExpect(sbcPkg::IO_WRITE, {8'h00, sbcPkg::PORT_PANEL}, r[31:24], 3);
        expectValue("frontPanel", 32'(frontPanel), 32'(r[31:24]));
        ioByteSw   = r[23:16];
        s100DataIn = ~r[23:16];
        readExpect(sbcPkg::IO_READ, {r[7:0], sbcPkg::PORT_RAMPAGE}, r[23:16], 3);
        writeExpect(sbcPkg::IO_WRITE, 16'h0042, ~r[31:24], 3);   // unlisted port
        expectValue("sbcLeds", 32'(sbcLeds), {24'h000000, ~r[7:0]});
        expectValue("frontPanel", 32'(frontPanel), 32'(r[31:24]));
        readExpect(sbcPkg::IO_READ, {r[31:24], 8'h42}, ~r[23:16], 3);
        expectValue("s100Addr high byte", 32'(s100Addr[15:8]), 0);
    endtask

    task automatic miscControl();
        logic [31:0] r;
        r = nextRand();
        writeExpect(sbcPkg::IO_WRITE, {8'h00, sbcPkg::PORT_MISC}, 8'h01, 3);    // bank 1
        readExpect(sbcPkg::MEM_READ, {sbcPkg::ROM_PAGE, r[7:0]}, romByte(1'b1, r[7:0]), 4);
        writeExpect(sbcPkg::IO_WRITE, {8'h00, sbcPkg::PORT_MISC}, 8'h00, 3);
        writeExpect(sbcPkg::MEM_WRITE, 16'h0020, r[15:8], 2);     // shadow write
        expectValue("ramNCs low on ROM window write", 32'(sawRamCs), 1);
        readExpect(sbcPkg::MEM_READ, 16'h0020, romByte(1'b0, 8'h20), 4);
        writeExpect(sbcPkg::IO_WRITE, {8'h00, sbcPkg::PORT_MISC}, 8'h02, 3);    // ROM off
        writeExpect(sbcPkg::MEM_WRITE, 16'h0010, r[23:16], 2);
        readExpect(sbcPkg::MEM_READ, 16'h0010, r[23:16], 2);
        readExpect(sbcPkg::MEM_READ, 16'h0020, r[15:8], 2);
        writeExpect(sbcPkg::IO_WRITE, {8'h00, sbcPkg::PORT_MISC}, 8'h00, 3);
    endtask

    task automatic statusHold();
        logic [31:0]    r;
        logic [15:0]    addr;
        logic           isIo;
        logic           isWr;
        sbcPkg::busKind kind;
        for (int i = 0; i < 4; i++) begin
            kind = sbcPkg::busKind'(i[1:0]);
            r    = nextRand();
            isIo = (kind == sbcPkg::IO_READ) || (kind == sbcPkg::IO_WRITE);
            isWr = (kind == sbcPkg::MEM_WRITE) || (kind == sbcPkg::IO_WRITE);
            addr = isIo ? {r[15:8], 8'h42} : r[15:0];             // port 42 holds no state
            runCycle(kind, addr, r[23:16]);
            for (int j = 0; j < 2; j++) begin                     // at done and again while idle
                expectValue("sMemr", 32'(sMemr), 32'(kind == sbcPkg::MEM_READ));
                expectValue("sInp", 32'(sInp), 32'(kind == sbcPkg::IO_READ));
                expectValue("sOut", 32'(sOut), 32'(kind == sbcPkg::IO_WRITE));
                expectValue("nSWo", 32'(nSWo), 32'(!isWr));
                expectValue("s100Addr", 32'(s100Addr), isIo ? {24'h0, addr[7:0]} : 32'(addr));
                if (isWr) begin
                    expectValue("s100DataOut", 32'(s100DataOut), 32'(r[23:16]));
                end
                repeat (3) @(negedge pll0_2MHz);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // sequence and watchdog
    //////////////////////////////////////////////////////////////////////
    initial begin
        n_reset    = 1'b0;
        busReq     = 1'b0;
        busKind    = sbcPkg::MEM_READ;
        busAddr    = 16'h0000;
        busWData   = 8'h00;
        ioByteSw   = 8'h00;
        s100DataIn = 8'h00;
        lcgState   = 32'h45ba;
        checkCount = 0;
        errorCount = 0;
        repeat (RESET_CYCLES) @(posedge pll0_2MHz);
        @(negedge pll0_2MHz);
        n_reset = 1'b1;
        @(negedge pll0_2MHz);
        romAfterReset();
        ramWriteRead();
        ioPortAccess();
        miscControl();
        statusHold();
        $display("checks %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: tests still running after %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/s100Glue.sv
// CPU side is a one-cycle busReq strobe with no back-pressure; latency is 2 RAM, 4 ROM, 3 I/O
`timescale 1ns/10ps
`default_nettype none

module s100Glue (
    input  logic                           pll0_2MHz,
    input  logic                           n_reset,
    input  logic                           busReq,
    input  sbcPkg::busKind                 busKind,
    input  logic [sbcPkg::ADDR_WIDTH-1:0]  busAddr,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  busWData,
    output logic                           cycleDone,
    output logic [sbcPkg::DATA_WIDTH-1:0]  readData,
    // RAM chip
    output logic [sbcPkg::ADDR_WIDTH-1:0]  ramAddr,
    output logic                           ramA16,
    output logic                           ramNCs,
    output logic                           ramNOe,
    output logic                           ramNWr,
    output logic [sbcPkg::DATA_WIDTH-1:0]  biDataOut,
    output logic                           biDataOe,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  biDataIn,
    // board I/O
    input  logic [sbcPkg::DATA_WIDTH-1:0]  ioByteSw,
    output logic [sbcPkg::DATA_WIDTH-1:0]  sbcLeds,
    output logic [sbcPkg::DATA_WIDTH-1:0]  frontPanel,
    // S-100 bus
    input  logic [sbcPkg::DATA_WIDTH-1:0]  s100DataIn,
    output logic [sbcPkg::ADDR_WIDTH-1:0]  s100Addr,
    output logic                           sMemr,
    output logic                           sInp,
    output logic                           sOut,
    output logic                           nSWo,
    output logic                           pSync,
    output logic                           pDbin,
    output logic                           nPWr,
    output logic [sbcPkg::DATA_WIDTH-1:0]  s100DataOut
);

    logic                          romBank;
    logic                          romOff;
    logic                          ramPage;
    logic                          memDone;
    logic [sbcPkg::DATA_WIDTH-1:0] memRData;
    logic                          ioDone;
    logic [sbcPkg::DATA_WIDTH-1:0] ioRData;

    memMap memMapInst (
        .pll0_2MHz (pll0_2MHz), .n_reset (n_reset),
        .busReq    (busReq),    .busKind (busKind),
        .busAddr   (busAddr),   .busWData (busWData),
        .romBank   (romBank),   .romOff  (romOff),    .ramPage (ramPage),
        .ramAddr   (ramAddr),   .ramA16  (ramA16),
        .ramNCs    (ramNCs),    .ramNOe  (ramNOe),    .ramNWr  (ramNWr),
        .biDataOut (biDataOut), .biDataOe (biDataOe), .biDataIn (biDataIn),
        .memDone   (memDone),   .memRData (memRData)
    );

    ioPorts ioPortsInst (
        .pll0_2MHz  (pll0_2MHz),  .n_reset    (n_reset),
        .busReq     (busReq),     .busKind    (busKind),
        .busAddr    (busAddr),    .busWData   (busWData),
        .ioByteSw   (ioByteSw),   .s100DataIn (s100DataIn),
        .sbcLeds    (sbcLeds),    .frontPanel (frontPanel),
        .romBank    (romBank),    .romOff     (romOff),     .ramPage (ramPage),
        .ioDone     (ioDone),     .ioRData    (ioRData)
    );

    busCycle busCycleInst (
        .pll0_2MHz   (pll0_2MHz),   .n_reset   (n_reset),
        .busReq      (busReq),      .busKind   (busKind),
        .busAddr     (busAddr),     .busWData  (busWData),
        .memDone     (memDone),     .memRData  (memRData),
        .ioDone      (ioDone),      .ioRData   (ioRData),
        .s100Addr    (s100Addr),
        .sMemr       (sMemr),       .sInp      (sInp),
        .sOut        (sOut),        .nSWo      (nSWo),
        .pSync       (pSync),       .pDbin     (pDbin),      .nPWr (nPWr),
        .s100DataOut (s100DataOut),
        .cycleDone   (cycleDone),   .readData  (readData)
    );

endmodule

`default_nettype wire

//--- rtl/busCycle.sv
// status and address hold from one request to the next; exactly one of memDone/ioDone fires per cycle
`timescale 1ns/10ps
`default_nettype none

module busCycle (
    input  logic                           pll0_2MHz,
    input  logic                           n_reset,
    input  logic                           busReq,
    input  sbcPkg::busKind                 busKind,
    input  logic [sbcPkg::ADDR_WIDTH-1:0]  busAddr,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  busWData,
    input  logic                           memDone,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  memRData,
    input  logic                           ioDone,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  ioRData,
    output logic [sbcPkg::ADDR_WIDTH-1:0]  s100Addr,
    output logic                           sMemr,
    output logic                           sInp,
    output logic                           sOut,
    output logic                           nSWo,        // low on any write
    output logic                           pSync,
    output logic                           pDbin,
    output logic                           nPWr,
    output logic [sbcPkg::DATA_WIDTH-1:0]  s100DataOut,
    output logic                           cycleDone,
    output logic [sbcPkg::DATA_WIDTH-1:0]  readData
);

    logic isIo;
    logic isRead;
    logic anyDone;

    assign isIo    = (busKind == sbcPkg::IO_READ) || (busKind == sbcPkg::IO_WRITE);
    assign isRead  = (busKind == sbcPkg::MEM_READ) || (busKind == sbcPkg::IO_READ);
    assign anyDone = memDone || ioDone;

    //////////////////////////////////////////////////////////////////////
    // S-100 status, latched at request
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            sMemr <= 1'b0;
            sInp  <= 1'b0;
            sOut  <= 1'b0;
            nSWo  <= 1'b1;
        end else if (busReq) begin
            sMemr <= (busKind == sbcPkg::MEM_READ);
            sInp  <= (busKind == sbcPkg::IO_READ);
            sOut  <= (busKind == sbcPkg::IO_WRITE);
            nSWo  <= isRead;                                  // active low write out
        end
    end

    // address and write data
    always_ff @(posedge pll0_2MHz) begin
        if (busReq) begin
            s100Addr <= isIo ? {8'h00, busAddr[7:0]} : busAddr;   // A15-8 zero on I/O
            if (!isRead) begin
                s100DataOut <= busWData;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // control strobes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            pSync <= 1'b0;
            pDbin <= 1'b0;
            nPWr  <= 1'b1;
        end else begin
            pSync <= busReq;                                  // first bus state only
            if (busReq) begin
                pDbin <= isRead;
                nPWr  <= isRead;
            end else if (anyDone) begin
                pDbin <= 1'b0;                                // drops as cycleDone rises
                nPWr  <= 1'b1;
            end
        end
    end

    // merge the two completion paths
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            cycleDone <= 1'b0;
        end else begin
            cycleDone <= anyDone;
        end
    end

    always_ff @(posedge pll0_2MHz) begin
        if (anyDone) begin
            readData <= memDone ? memRData : ioRData;         // whichever side finished
        end
    end

endmodule

`default_nettype wire

//--- rtl/ioPorts.sv
// only ports 06, 07, 36 and FF hold state; other IN ports read the S-100 data-in bus
`timescale 1ns/10ps
`default_nettype none

module ioPorts (
    input  logic                           pll0_2MHz,
    input  logic                           n_reset,
    input  logic                           busReq,
    input  sbcPkg::busKind                 busKind,
    input  logic [sbcPkg::ADDR_WIDTH-1:0]  busAddr,     // low byte is the port
    input  logic [sbcPkg::DATA_WIDTH-1:0]  busWData,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  ioByteSw,    // board switches
    input  logic [sbcPkg::DATA_WIDTH-1:0]  s100DataIn,
    output logic [sbcPkg::DATA_WIDTH-1:0]  sbcLeds,     // low lights an LED
    output logic [sbcPkg::DATA_WIDTH-1:0]  frontPanel,
    output logic                           romBank,
    output logic                           romOff,
    output logic                           ramPage,
    output logic                           ioDone,
    output logic [sbcPkg::DATA_WIDTH-1:0]  ioRData
);

    logic [sbcPkg::DATA_WIDTH-1:0] ledReg;
    logic [sbcPkg::DATA_WIDTH-1:0] miscReg;
    logic [sbcPkg::DATA_WIDTH-1:0] panelReg;
    logic                          pageReg;
    logic [7:0]                    portQ;
    logic [sbcPkg::DATA_WIDTH-1:0] wDataQ;
    logic [sbcPkg::WAIT_WIDTH-1:0] waitCnt;
    logic                          active;
    logic                          isWrite;
    logic                          ioKind;

    assign ioKind = (busKind == sbcPkg::IO_READ) || (busKind == sbcPkg::IO_WRITE);

    //////////////////////////////////////////////////////////////////////
    // cycle timing
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            active  <= 1'b0;
            waitCnt <= '0;
        end else if (busReq && ioKind) begin
            active  <= 1'b1;
            waitCnt <= sbcPkg::IO_WAITS;
        end else if (ioDone) begin
            active  <= 1'b0;
        end else if (active) begin
            waitCnt <= waitCnt - 1'b1;
        end
    end

    always_ff @(posedge pll0_2MHz) begin
        if (busReq && ioKind) begin
            portQ   <= busAddr[7:0];                          // Z80 puts A on the high byte
            wDataQ  <= busWData;
            isWrite <= (busKind == sbcPkg::IO_WRITE);
        end
    end

    assign ioDone = active && (waitCnt == '0);

    //////////////////////////////////////////////////////////////////////
    // port registers, loaded as the done cycle closes
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            ledReg   <= '0;                                   // LEDs dark
            miscReg  <= '0;                                   // ROM on, bank 0
            panelReg <= '0;
            pageReg  <= 1'b0;
        end else if (ioDone && isWrite) begin
            case (portQ)
                sbcPkg::PORT_LEDBAR:  ledReg   <= wDataQ;
                sbcPkg::PORT_MISC:    miscReg  <= wDataQ;
                sbcPkg::PORT_RAMPAGE: pageReg  <= wDataQ[0];  // only D0 kept
                sbcPkg::PORT_PANEL:   panelReg <= wDataQ;
                default: ;                                    // unlisted port, ignored
            endcase
        end
    end

    // read mux
    always_comb begin
        case (portQ)
            sbcPkg::PORT_LEDBAR:  ioRData = ledReg;
            sbcPkg::PORT_RAMPAGE: ioRData = ioByteSw;
            default:              ioRData = s100DataIn;       // off-board card answers
        endcase
    end

    assign sbcLeds    = ~ledReg;                              // inverted drive
    assign frontPanel = panelReg;
    assign romBank    = miscReg[sbcPkg::MISC_ROMBANK];
    assign romOff     = miscReg[sbcPkg::MISC_ROMOFF];
    assign ramPage    = pageReg;

endmodule

`default_nettype wire

//--- memory/memMap.sv
// ROM window 0000-00FF only while romOff is clear; ROM image comes from memory/bootRom.hex
`timescale 1ns/10ps
`default_nettype none

module memMap (
    input  logic                           pll0_2MHz,
    input  logic                           n_reset,
    input  logic                           busReq,      // one-cycle request strobe
    input  sbcPkg::busKind                 busKind,
    input  logic [sbcPkg::ADDR_WIDTH-1:0]  busAddr,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  busWData,
    input  logic                           romBank,     // from misc port
    input  logic                           romOff,
    input  logic                           ramPage,     // from port 36 bit 0
    output logic [sbcPkg::ADDR_WIDTH-1:0]  ramAddr,
    output logic                           ramA16,
    output logic                           ramNCs,
    output logic                           ramNOe,
    output logic                           ramNWr,
    output logic [sbcPkg::DATA_WIDTH-1:0]  biDataOut,
    output logic                           biDataOe,
    input  logic [sbcPkg::DATA_WIDTH-1:0]  biDataIn,
    output logic                           memDone,
    output logic [sbcPkg::DATA_WIDTH-1:0]  memRData
);

    logic [sbcPkg::DATA_WIDTH-1:0] romMem [sbcPkg::ROM_BYTES];
    logic [sbcPkg::ROM_AW-1:0]     romIdx;
    logic [sbcPkg::ADDR_WIDTH-1:0] addrQ;
    logic [sbcPkg::DATA_WIDTH-1:0] wDataQ;
    logic [sbcPkg::DATA_WIDTH-1:0] romDataQ;
    logic [sbcPkg::WAIT_WIDTH-1:0] waitCnt;
    logic                          active;
    logic                          isWrite;
    logic                          isRom;
    logic                          memKind;
    logic                          romHit;
    logic                          ramSel;

    initial $readmemh("memory/bootRom.hex", romMem);

    //////////////////////////////////////////////////////////////////////
    // decode at request time
    //////////////////////////////////////////////////////////////////////
    assign memKind = (busKind == sbcPkg::MEM_READ) || (busKind == sbcPkg::MEM_WRITE);
    assign romHit  = (busKind == sbcPkg::MEM_READ) && !romOff
                     && (busAddr[sbcPkg::ADDR_WIDTH-1 -: 8] == sbcPkg::ROM_PAGE);
    assign romIdx  = {romBank, busAddr[7:0]};                 // bank bit on top

    // wait counter, memDone once it has run down
    always_ff @(posedge pll0_2MHz) begin
        if (!n_reset) begin
            active  <= 1'b0;
            waitCnt <= '0;
        end else if (busReq && memKind) begin
            active  <= 1'b1;
            waitCnt <= romHit ? sbcPkg::ROM_WAITS : sbcPkg::RAM_WAITS;
        end else if (memDone) begin
            active  <= 1'b0;                                  // cycle finished
        end else if (active) begin
            waitCnt <= waitCnt - 1'b1;                        // one wait state gone
        end
    end

    // cycle payload, held for the whole cycle
    always_ff @(posedge pll0_2MHz) begin
        if (busReq && memKind) begin
            addrQ    <= busAddr;
            wDataQ   <= busWData;
            isWrite  <= (busKind == sbcPkg::MEM_WRITE);
            isRom    <= romHit;
            romDataQ <= romMem[romIdx];                       // registered ROM output
        end
    end

    assign memDone = active && (waitCnt == '0);

    //////////////////////////////////////////////////////////////////////
    // RAM chip pins
    //////////////////////////////////////////////////////////////////////
    assign ramSel    = active && !isRom;                      // ROM window writes shadow here
    assign ramAddr   = addrQ;
    assign ramA16    = ramPage && !addrQ[sbcPkg::ADDR_WIDTH-1];   // upper 32K never paged
    assign ramNCs    = !ramSel;
    assign ramNOe    = !(ramSel && !isWrite);
    assign ramNWr    = !(ramSel && isWrite);
    assign biDataOe  = ramSel && isWrite;                     // drive chip data on writes
    assign biDataOut = wDataQ;

    assign memRData  = isRom ? romDataQ : biDataIn;           // RAM sampled in memDone cycle

endmodule

`default_nettype wire

//--- common/sbcPkg.sv
// shared bus definitions for the S-100 glue; assumes one bus cycle in flight and no back-pressure
`default_nettype none

package sbcPkg;

    //////////////////////////////////////////////////////////////////////
    // bus cycle kinds issued by the CPU side
    //////////////////////////////////////////////////////////////////////
    typedef enum logic [1:0] {
        MEM_READ  = 2'b00,                  // memory read
        MEM_WRITE = 2'b01,                  // memory write
        IO_READ   = 2'b10,                  // IN instruction
        IO_WRITE  = 2'b11                   // OUT instruction
    } busKind;

    localparam int DATA_WIDTH = 8;          // data bus byte
    localparam int ADDR_WIDTH = 16;         // Z80 address space

    //////////////////////////////////////////////////////////////////////
    // on-board I/O ports
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] PORT_LEDBAR  = 8'h06;    // LED bar, readback too
    localparam logic [7:0] PORT_MISC    = 8'h07;    // misc control
    localparam logic [7:0] PORT_RAMPAGE = 8'h36;    // out = RAM page, in = switches
    localparam logic [7:0] PORT_PANEL   = 8'hFF;    // front panel lamps

    // misc register bit positions
    localparam int MISC_ROMBANK = 0;        // selects upper ROM half
    localparam int MISC_ROMOFF  = 1;        // ROM window off, RAM everywhere

    //////////////////////////////////////////////////////////////////////
    // memory map
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] ROM_PAGE = 8'h00;    // high byte of the ROM window
    localparam int ROM_BYTES = 512;             // two banks of 256
    localparam int ROM_AW    = 9;               // bank bit plus low address byte

    // added wait cycles per target
    localparam int WAIT_WIDTH = 2;
    localparam logic [WAIT_WIDTH-1:0] ROM_WAITS = 2'd2;
    localparam logic [WAIT_WIDTH-1:0] RAM_WAITS = 2'd0;
    localparam logic [WAIT_WIDTH-1:0] IO_WAITS  = 2'd1;

endpackage

`default_nettype wire
